// ==== logic/uart_frame_pkg.sv ====
package uart_frame_pkg;

    localparam int MIN_DATA_BITS = 5;
    localparam int MAX_DATA_BITS = 9;                   // Also the data word width

    typedef enum logic [2:0] {
        par_none   = 3'b000,
        par_odd    = 3'b001,
        par_even   = 3'b010,
        par_stick0 = 3'b100,
        par_stick1 = 3'b101
    } parity_mode_t;

    typedef logic [3:0] data_size_t;
    typedef logic [MAX_DATA_BITS-1:0] data_word_t;      // Right-aligned

    // Bit slot sequence, common to both directions
    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop0,
        st_stop1
    } frame_state_t;

    function automatic logic parity_bit(data_word_t word, data_size_t size, parity_mode_t mode);
        data_word_t masked;
        masked = word & ~({MAX_DATA_BITS{1'b1}} << size);   // Drop bits above size
        case (mode)
            par_odd:    parity_bit = ~^masked;
            par_even:   parity_bit = ^masked;
            par_stick1: parity_bit = 1'b1;
            default:    parity_bit = 1'b0;
        endcase
    endfunction

    function automatic logic parity_enabled(parity_mode_t mode);
        parity_enabled = mode inside {par_odd, par_even, par_stick0, par_stick1};
    endfunction

endpackage

// ==== logic/uart_timing_pkg.sv ====
package uart_timing_pkg;

    localparam int SAMPLES_PER_BIT = 8;                 // Baud ticks per bit
    localparam int SAMPLE_W        = $clog2(SAMPLES_PER_BIT);

    typedef logic [15:0] prescale_t;

    localparam int FIFO_ADDR_W = 4;
    localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;
    typedef logic [FIFO_ADDR_W:0] fifo_level_t;         // 0 to FIFO_DEPTH

    localparam int CFG_ADDR_W = 2;
    typedef logic [15:0] cfg_data_t;

    localparam logic [CFG_ADDR_W-1:0] REG_PRESCALE = 2'd0;
    localparam logic [CFG_ADDR_W-1:0] REG_CONTROL  = 2'd1;
    localparam logic [CFG_ADDR_W-1:0] REG_FRAME    = 2'd2;

endpackage

// ==== logic/uart_cfg_regs.sv ====
`timescale 1ns/100ps

module uart_cfg_regs (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    cfg_wr,
    input  logic [uart_timing_pkg::CFG_ADDR_W-1:0]  cfg_addr,
    input  uart_timing_pkg::cfg_data_t              cfg_wdata,
    output uart_timing_pkg::prescale_t              prescale,
    output logic                                    en,
    output logic                                    tx_en,
    output logic                                    rx_en,
    output logic                                    loopback,
    output uart_frame_pkg::data_size_t              data_size,
    output logic                                    two_stop,
    output uart_frame_pkg::parity_mode_t            parity
);
    import uart_timing_pkg::*;
    import uart_frame_pkg::*;

    logic [3:0] control_q;                              // loopback, rx_en, tx_en, en
    logic [2:0] size_ofs_q;                             // Data size minus MIN_DATA_BITS
    logic [2:0] size_ofs_next;

    // Saturate the written size into 5..9
    always_comb begin
        if (cfg_wdata[3:0] < 4'(MIN_DATA_BITS))
            size_ofs_next = '0;
        else if (cfg_wdata[3:0] > 4'(MAX_DATA_BITS))
            size_ofs_next = 3'(MAX_DATA_BITS - MIN_DATA_BITS);
        else
            size_ofs_next = 3'(cfg_wdata[3:0] - 4'(MIN_DATA_BITS));
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            prescale   <= '0;
            control_q  <= '0;
            size_ofs_q <= '0;                           // Zero means 5 data bits
            two_stop   <= 1'b0;
            parity     <= par_none;
        end else if (cfg_wr) begin
            case (cfg_addr)
                REG_PRESCALE: prescale <= cfg_wdata;
                REG_CONTROL:  control_q <= cfg_wdata[3:0];
                REG_FRAME: begin
                    size_ofs_q <= size_ofs_next;
                    two_stop   <= cfg_wdata[4];
                    parity     <= parity_mode_t'(cfg_wdata[7:5]);
                end
                default: ;                              // Unmapped address
            endcase
        end
    end

    assign {loopback, rx_en, tx_en, en} = control_q;
    assign data_size = data_size_t'(size_ofs_q) + data_size_t'(MIN_DATA_BITS);

    a_size_range: assert property (@(posedge clk) disable iff (!resetn)
        data_size inside {[MIN_DATA_BITS:MAX_DATA_BITS]});

endmodule

// ==== logic/uart_baud_gen.sv ====
`timescale 1ns/100ps

module uart_baud_gen (
    input  logic                        clk,
    input  logic                        resetn,
    input  uart_timing_pkg::prescale_t  prescale,
    input  logic                        en,
    input  logic                        tx_en,
    input  logic                        rx_en,
    output logic                        tx_tick,
    output logic                        rx_tick
);
    import uart_timing_pkg::*;

    prescale_t count_q;
    logic      wrap;

    assign wrap = en && (count_q >= prescale);          // Also recovers if prescale shrinks

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn)
            count_q <= '0;
        else if (en)
            count_q <= wrap ? '0 : count_q + 16'd1;
    end

    assign tx_tick = wrap && tx_en;
    assign rx_tick = wrap && rx_en;

    // Counter settles within 0 to prescale one cycle after a change
    a_count_range: assert property (@(posedge clk) disable iff (!resetn)
        en && $past(en) && $stable(prescale) |-> count_q <= prescale);

endmodule

// ==== logic/uart_fifo.sv ====
`timescale 1ns/100ps

module uart_fifo (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            wr,
    input  uart_frame_pkg::data_word_t      wdata,
    input  logic                            rd,
    output uart_frame_pkg::data_word_t      rdata,
    output logic                            empty,
    output logic                            full,
    output uart_timing_pkg::fifo_level_t    level
);
    import uart_frame_pkg::*;
    import uart_timing_pkg::*;

    data_word_t             mem [FIFO_DEPTH];
    logic [FIFO_ADDR_W-1:0] wr_ptr;
    logic [FIFO_ADDR_W-1:0] rd_ptr;
    logic                   push;
    logic                   pop;

    assign push = wr && !full;                          // Overflow dropped
    assign pop  = rd && !empty;                         // Underflow dropped

    always_ff @(posedge clk) begin
        if (push)
            mem[wr_ptr] <= wdata;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            level  <= '0;
        end else begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (push && !pop)
                level <= level + 1'b1;
            else if (pop && !push)
                level <= level - 1'b1;
        end
    end

    assign rdata = mem[rd_ptr];                         // Head word, fall-through
    assign empty = (level == '0);
    assign full  = (level == fifo_level_t'(FIFO_DEPTH));

    a_level_max: assert property (@(posedge clk) disable iff (!resetn)
        level <= fifo_level_t'(FIFO_DEPTH));

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/100ps

module uart_tx (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            tick,
    input  logic                            start,
    input  uart_frame_pkg::data_word_t      din,
    input  uart_frame_pkg::data_size_t      data_size,
    input  logic                            two_stop,
    input  uart_frame_pkg::parity_mode_t   parity,
    output logic                            tx_done,
    output logic                            tx
);
    import uart_frame_pkg::*;
    import uart_timing_pkg::*;

    frame_state_t        state_q;
    logic [SAMPLE_W-1:0] tick_cnt_q;
    data_size_t          bit_cnt_q;
    data_word_t          shift_q;
    logic                par_q;
    logic                bit_end;

    assign bit_end = tick && (tick_cnt_q == SAMPLE_W'(SAMPLES_PER_BIT - 1));

    // Frame payload, loaded from the FIFO head
    always_ff @(posedge clk) begin
        if (state_q == st_idle && start) begin
            shift_q <= din;
            par_q   <= parity_bit(din, data_size, parity);
        end else if (state_q == st_data && bit_end)
            shift_q <= shift_q >> 1;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q    <= st_idle;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            tx         <= 1'b1;                         // Line idles high
        end else begin
            if (state_q == st_idle)
                tick_cnt_q <= '0;
            else if (tick)
                tick_cnt_q <= bit_end ? '0 : tick_cnt_q + 1'b1;
            case (state_q)
                st_idle: begin
                    tx <= 1'b1;
                    if (start) begin
                        state_q <= st_start;
                        tx      <= 1'b0;
                    end
                end
                st_start: if (bit_end) begin
                    state_q   <= st_data;
                    bit_cnt_q <= '0;
                    tx        <= shift_q[0];            // LSB first
                end
                st_data: if (bit_end) begin
                    if (bit_cnt_q == data_size - 4'd1) begin
                        state_q <= parity_enabled(parity) ? st_parity : st_stop0;
                        tx      <= parity_enabled(parity) ? par_q : 1'b1;
                    end else begin
                        bit_cnt_q <= bit_cnt_q + 4'd1;
                        tx        <= shift_q[1];        // Next bit before the shift lands
                    end
                end
                st_parity: if (bit_end) begin
                    state_q <= st_stop0;
                    tx      <= 1'b1;
                end
                st_stop0: if (bit_end)
                    state_q <= two_stop ? st_stop1 : st_idle;
                st_stop1: if (bit_end)
                    state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    // Pops the FIFO as the frame ends
    assign tx_done = bit_end && ((state_q == st_stop0 && !two_stop) || state_q == st_stop1);

    a_idle_high: assert property (@(posedge clk) disable iff (!resetn)
        state_q == st_idle |-> tx);

endmodule

// ==== logic/uart_rx.sv ====
`timescale 1ns/100ps

module uart_rx (
    input  logic                            clk,
    input  logic                            resetn,
    input  logic                            tick,
    input  logic                            rx,
    input  logic                            tx_loop,
    input  logic                            loopback,
    input  uart_frame_pkg::data_size_t      data_size,
    input  logic                            two_stop,
    input  uart_frame_pkg::parity_mode_t   parity,
    output logic                            rx_done,
    output uart_frame_pkg::data_word_t      dout,
    output logic                            parity_error,
    output logic                            frame_error
);
    import uart_frame_pkg::*;
    import uart_timing_pkg::*;

    logic                rx_meta;
    logic                rx_sync;
    logic                line;
    frame_state_t        state_q;
    logic [SAMPLE_W-1:0] tick_cnt_q;
    data_size_t          bit_cnt_q;
    data_word_t          shift_q;
    logic                perr_q;
    logic                ferr_q;
    logic                bit_end;
    logic                half_end;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end
    end

    assign line     = loopback ? tx_loop : rx_sync;     // Loopback bypasses the pin
    assign bit_end  = tick && (tick_cnt_q == SAMPLE_W'(SAMPLES_PER_BIT - 1));
    assign half_end = tick && (tick_cnt_q == SAMPLE_W'(SAMPLES_PER_BIT / 2 - 1));

    // Bits arrive LSB first, so they enter from the top
    always_ff @(posedge clk) begin
        if (state_q == st_data && bit_end)
            shift_q <= {line, shift_q[MAX_DATA_BITS-1:1]};
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q    <= st_idle;
            tick_cnt_q <= '0;
            bit_cnt_q  <= '0;
            perr_q     <= 1'b0;
            ferr_q     <= 1'b0;
        end else begin
            if (state_q == st_idle || (state_q == st_start && half_end))
                tick_cnt_q <= '0;
            else if (tick)
                tick_cnt_q <= bit_end ? '0 : tick_cnt_q + 1'b1;
            case (state_q)
                st_idle: begin
                    perr_q <= 1'b0;
                    ferr_q <= 1'b0;
                    if (tick && !line)
                        state_q <= st_start;
                end
                st_start: if (half_end) begin
                    state_q   <= line ? st_idle : st_data;   // High again is a false start
                    bit_cnt_q <= '0;
                end
                st_data: if (bit_end) begin
                    if (bit_cnt_q == data_size - 4'd1)
                        state_q <= parity_enabled(parity) ? st_parity : st_stop0;
                    else
                        bit_cnt_q <= bit_cnt_q + 4'd1;
                end
                st_parity: if (bit_end) begin
                    perr_q  <= (line != parity_bit(dout, data_size, parity));
                    state_q <= st_stop0;
                end
                st_stop0: if (bit_end) begin
                    ferr_q  <= !line;
                    state_q <= two_stop ? st_stop1 : st_idle;
                end
                st_stop1: if (bit_end)
                    state_q <= st_idle;
                default: state_q <= st_idle;
            endcase
        end
    end

    assign rx_done      = bit_end && ((state_q == st_stop0 && !two_stop) || state_q == st_stop1);
    assign dout         = shift_q >> (4'(MAX_DATA_BITS) - data_size);
    assign parity_error = rx_done && perr_q;
    assign frame_error  = rx_done && (ferr_q || !line);     // Last stop bit sampled now

endmodule

// ==== logic/uart_top.sv ====
`timescale 1ns/100ps

module uart_top (
    input  logic                                    clk,
    input  logic                                    resetn,
    input  logic                                    cfg_wr,
    input  logic [uart_timing_pkg::CFG_ADDR_W-1:0]  cfg_addr,
    input  uart_timing_pkg::cfg_data_t              cfg_wdata,
    input  logic                                    tx_wr,
    input  uart_frame_pkg::data_word_t              tx_wdata,
    output logic                                    tx_full,
    output logic                                    tx_empty,
    output uart_timing_pkg::fifo_level_t            tx_level,
    input  logic                                    rx_rd,
    output uart_frame_pkg::data_word_t              rx_rdata,
    output logic                                    rx_empty,
    output logic                                    rx_full,
    output uart_timing_pkg::fifo_level_t            rx_level,
    output logic                                    parity_error,
    output logic                                    frame_error,
    output logic                                    overrun,
    input  logic                                    rx,
    output logic                                    tx
);
    import uart_frame_pkg::*;
    import uart_timing_pkg::*;

    prescale_t    prescale;
    logic         en;
    logic         tx_en;
    logic         rx_en;
    logic         loopback;
    data_size_t   data_size;
    logic         two_stop;
    parity_mode_t parity;
    logic         tx_tick;
    logic         rx_tick;
    data_word_t   tx_head;
    logic         tx_done;
    data_word_t   rx_data;
    logic         rx_done;

    uart_cfg_regs u_cfg_regs (
        .clk, .resetn, .cfg_wr, .cfg_addr, .cfg_wdata, .prescale, .en,
        .tx_en, .rx_en, .loopback, .data_size, .two_stop, .parity
    );

    uart_baud_gen u_baud_gen (
        .clk, .resetn, .prescale, .en, .tx_en, .rx_en, .tx_tick, .rx_tick
    );

    uart_fifo u_tx_fifo (
        .clk, .resetn, .wr(tx_wr), .wdata(tx_wdata), .rd(tx_done),
        .rdata(tx_head), .empty(tx_empty), .full(tx_full), .level(tx_level)
    );

    uart_tx u_tx (
        .clk, .resetn, .tick(tx_tick), .start(!tx_empty), .din(tx_head),
        .data_size, .two_stop, .parity, .tx_done, .tx
    );

    uart_rx u_rx (
        .clk, .resetn, .tick(rx_tick), .rx, .tx_loop(tx), .loopback, .data_size,
        .two_stop, .parity, .rx_done, .dout(rx_data), .parity_error, .frame_error
    );

    uart_fifo u_rx_fifo (
        .clk, .resetn, .wr(rx_done), .wdata(rx_data), .rd(rx_rd),
        .rdata(rx_rdata), .empty(rx_empty), .full(rx_full), .level(rx_level)
    );

    assign overrun = rx_done & rx_full;                 // Frame lost

endmodule

// ==== tb/uart_tb.sv ====
`timescale 1ns/100ps

module uart_tb;
    import uart_frame_pkg::*;
    import uart_timing_pkg::*;

    localparam int TOTAL_FRAMES   = 41;                 // 6 + 15 + 1 + 2 + 17
    localparam int TIMEOUT_CYCLES = TOTAL_FRAMES * 12 * 16 * 2 + 1000;

    logic                  clk;
    logic                  resetn;
    logic                  cfg_wr;
    logic [CFG_ADDR_W-1:0] cfg_addr;
    cfg_data_t             cfg_wdata;
    logic                  tx_wr;
    data_word_t            tx_wdata;
    logic                  tx_full;
    logic                  tx_empty;
    fifo_level_t           tx_level;
    logic                  rx_rd;
    data_word_t            rx_rdata;
    logic                  rx_empty;
    logic                  rx_full;
    fifo_level_t           rx_level;
    logic                  parity_error;
    logic                  frame_error;
    logic                  overrun;
    logic                  rx;
    logic                  tx;

    integer seed = 32'h9964_616c;
    int     cycles = 0;
    int     checks = 0;
    int     errors = 0;
    int     tests_run = 0;
    int     perr_count = 0;
    int     ferr_count = 0;
    int     ovr_count = 0;
    int     perr_base;
    int     ferr_base;
    int     ovr_base;
    int     err_base;

    uart_top u_uart_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not complete within %0d clock cycles",
                     TIMEOUT_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    // Event pulses are one cycle wide, so each is seen at one falling edge
    always @(negedge clk) begin
        if (resetn) begin
            if (parity_error)
                perr_count <= perr_count + 1;
            if (frame_error)
                ferr_count <= ferr_count + 1;
            if (overrun)
                ovr_count <= ovr_count + 1;
        end
    end

    task automatic check_eq(input logic [31:0] actual, input logic [31:0] expected,
                            input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR @%0t: %s: got 0x%0h, expected 0x%0h", $time, msg, actual, expected);
        end
    endtask

    function automatic cfg_data_t frame_word(input int size, input logic two,
                                             input parity_mode_t par);
        frame_word = cfg_data_t'(size) | (cfg_data_t'(two) << 4) | (cfg_data_t'(par) << 5);
    endfunction

    function automatic data_word_t size_mask(input int size);
        size_mask = data_word_t'((1 << size) - 1);
    endfunction

    // Odd and even count the ones among the used data bits
    function automatic logic expected_parity(input data_word_t word, input int size,
                                             input parity_mode_t mode);
        int ones;
        ones = $countones(word & size_mask(size));
        case (mode)
            par_odd:    expected_parity = (ones % 2 == 0);
            par_even:   expected_parity = (ones % 2 == 1);
            par_stick1: expected_parity = 1'b1;
            default:    expected_parity = 1'b0;
        endcase
    endfunction

    function automatic parity_mode_t mode_by_index(input int m);
        case (m)
            1:       mode_by_index = par_odd;
            2:       mode_by_index = par_even;
            3:       mode_by_index = par_stick0;
            4:       mode_by_index = par_stick1;
            default: mode_by_index = par_none;
        endcase
    endfunction

    task automatic cfg_write(input logic [CFG_ADDR_W-1:0] addr, input cfg_data_t data);
        @(posedge clk);
        #1;
        cfg_wr    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1 cfg_wr = 1'b0;
    endtask

    task automatic push_tx(input data_word_t word);
        @(posedge clk);
        #1;
        tx_wr    = 1'b1;
        tx_wdata = word;
        @(posedge clk);
        #1 tx_wr = 1'b0;
    endtask

    task automatic pop_rx(output data_word_t word);
        @(negedge clk);
        word = rx_rdata;                                // Head word before the pop
        @(posedge clk);
        #1 rx_rd = 1'b1;
        @(posedge clk);
        #1 rx_rd = 1'b0;
    endtask

    task automatic hold_rx(input logic value);          // One bit time on the rx pin
        @(posedge clk);
        #1 rx = value;
        repeat (15) @(posedge clk);
    endtask

    task automatic drive_serial(input data_word_t word, input int size, input logic par,
                                input logic stop);
        data_word_t bits;
        int         i;
        bits = word;
        hold_rx(1'b0);
        for (i = 0; i < size; i++) begin
            hold_rx(bits[0]);
            bits = bits >> 1;
        end
        hold_rx(par);
        hold_rx(stop);
        repeat (3) hold_rx(1'b1);                       // Idle gap
    endtask

    task automatic wait_rx_level(input int n);
        @(negedge clk);
        while (32'(rx_level) < n)
            @(negedge clk);
    endtask

    task automatic wait_tx_idle();
        @(negedge clk);
        while (!tx_empty)
            @(negedge clk);
    endtask

    task automatic start_test();
        perr_base = perr_count;
        ferr_base = ferr_count;
        ovr_base  = ovr_count;
        err_base  = errors;
    endtask

    task automatic finish_test(input string name, input int dp, input int df, input int dov);
        check_eq(perr_count - perr_base, dp, {name, ": parity_error pulses"});
        check_eq(ferr_count - ferr_base, df, {name, ": frame_error pulses"});
        check_eq(ovr_count - ovr_base, dov, {name, ": overrun pulses"});
        tests_run++;
        if (errors == err_base)
            $display("%s: ok", name);
        else
            $display("%s: %0d errors", name, errors - err_base);
    endtask

    task automatic loopback_round_trip();
        data_word_t sent [$];
        data_word_t word;
        data_word_t got;
        start_test();
        cfg_write(REG_FRAME, frame_word(8, 1'b0, par_none));
        cfg_write(REG_CONTROL, 16'h000f);               // en, tx_en, rx_en, loopback
        repeat (6) begin
            word = data_word_t'($random(seed));
            sent.push_back(word & size_mask(8));
            push_tx(word);
        end
        wait_rx_level(6);
        while (sent.size() > 0) begin
            pop_rx(got);
            check_eq(32'(got), 32'(sent.pop_front()), "loopback word");
        end
        wait_tx_idle();
        finish_test("loopback round trip", 0, 0, 0);
    endtask

    task automatic format_sweep();
        data_word_t   word;
        data_word_t   got;
        parity_mode_t mode;
        int           size;
        int           m;
        start_test();
        cfg_write(REG_CONTROL, 16'h000f);
        for (size = 5; size <= 9; size += 2) begin
            for (m = 0; m < 5; m++) begin
                mode = mode_by_index(m);
                cfg_write(REG_FRAME, frame_word(size, 1'b1, mode));
                word = data_word_t'($random(seed));
                push_tx(word);
                wait_rx_level(1);
                pop_rx(got);
                check_eq(32'(got), 32'(word & size_mask(size)),
                         $sformatf("sweep size %0d parity %0d", size, mode));
                wait_tx_idle();                         // Format changes only between frames
            end
        end
        finish_test("format sweep", 0, 0, 0);
    endtask

    task automatic line_format();
        data_word_t  word;
        logic [10:0] expected;                          // Start, 7 data, parity, 2 stop
        int          i;
        start_test();
        word = data_word_t'($random(seed));
        cfg_write(REG_CONTROL, 16'h0007);
        cfg_write(REG_FRAME, frame_word(7, 1'b1, par_odd));
        expected = {2'b11, expected_parity(word, 7, par_odd), word[6:0], 1'b0};
        push_tx(word);
        @(negedge clk);
        while (tx)
            @(negedge clk);
        repeat (8) @(negedge clk);                      // Centre of the start bit
        for (i = 0; i < 11; i++) begin
            check_eq(32'(tx), 32'(expected[0]), $sformatf("tx line bit %0d", i));
            expected = expected >> 1;
            if (i < 10)
                repeat (16) @(negedge clk);
        end
        wait_tx_idle();
        finish_test("serial line format", 0, 0, 0);
    endtask

    task automatic error_flags();
        data_word_t w0;
        data_word_t w1;
        data_word_t got;
        start_test();
        cfg_write(REG_CONTROL, 16'h0007);               // Receive from the rx pin
        cfg_write(REG_FRAME, frame_word(8, 1'b0, par_even));
        w0 = data_word_t'($random(seed)) & size_mask(8);
        w1 = data_word_t'($random(seed)) & size_mask(8);
        drive_serial(w0, 8, ~expected_parity(w0, 8, par_even), 1'b1);
        drive_serial(w1, 8, expected_parity(w1, 8, par_even), 1'b0);
        wait_rx_level(2);
        pop_rx(got);
        check_eq(32'(got), 32'(w0), "word with bad parity");
        pop_rx(got);
        check_eq(32'(got), 32'(w1), "word with low stop bit");
        finish_test("parity and framing errors", 1, 1, 0);
    endtask

    task automatic fifo_overrun();
        data_word_t sent [$];
        data_word_t word;
        data_word_t got;
        int         i;
        start_test();
        cfg_write(REG_CONTROL, 16'h0000);
        cfg_write(REG_FRAME, frame_word(8, 1'b0, par_none));
        for (i = 0; i < 17; i++) begin
            word = data_word_t'($random(seed)) & size_mask(8);
            sent.push_back(word);
            push_tx(word);
        end
        @(negedge clk);
        check_eq(32'(tx_full), 1, "tx_full after 17 pushes");
        check_eq(32'(tx_level), 16, "tx_level after 17 pushes");
        cfg_write(REG_CONTROL, 16'h000f);
        @(negedge clk);
        while (tx_full)
            @(negedge clk);
        push_tx(sent[16]);                              // The dropped word becomes frame 17
        wait_tx_idle();
        check_eq(32'(rx_full), 1, "rx_full after 17 frames");
        check_eq(32'(rx_level), 16, "rx_level after 17 frames");
        for (i = 0; i < 16; i++) begin
            pop_rx(got);
            check_eq(32'(got), 32'(sent.pop_front()), $sformatf("rx FIFO word %0d", i));
        end
        @(negedge clk);
        check_eq(32'(rx_empty), 1, "rx FIFO drained");
        finish_test("FIFO limits and overrun", 0, 0, 1);
    endtask

    initial begin
        resetn    = 1'b0;
        cfg_wr    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        tx_wr     = 1'b0;
        tx_wdata  = '0;
        rx_rd     = 1'b0;
        rx        = 1'b1;                               // Line idles high
        repeat (5) @(posedge clk);
        #1 resetn = 1'b1;
        @(negedge clk);
        check_eq(32'(tx), 1, "tx high after reset");
        check_eq(32'(tx_empty & rx_empty), 1, "FIFOs empty after reset");
        cfg_write(REG_PRESCALE, 16'd1);                 // 16 clocks per bit
        loopback_round_trip();
        format_sweep();
        line_format();
        error_flags();
        fifo_overrun();
        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// ==== files.f ====
logic/uart_frame_pkg.sv
logic/uart_timing_pkg.sv
logic/uart_cfg_regs.sv
logic/uart_baud_gen.sv
logic/uart_fifo.sv
logic/uart_tx.sv
logic/uart_rx.sv
logic/uart_top.sv
tb/uart_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= uart_tb
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= ** PASS **

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
